/* sources.f */
+incdir+.
tnoc_pkg.sv
tnoc_input_unit.sv
tnoc_output_switch.sv
tnoc_router.sv
tnoc_router_chk.sv
tnoc_router_tb.sv

/* run.sh */
#!/usr/bin/env bash
# builds the router testbench with Verilator, runs it and judges the log

set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f sources.f \
  --top-module tnoc_router_tb \
  -o tnoc_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tnoc_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test failed" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi

if ! grep -q "Test passed" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi

exit 0

/* tnoc_router_tb.sv */
`timescale 1ns/1ns

`include "tnoc_defines.svh"

module tnoc_router_tb;
  import tnoc_pkg::*;

  localparam int TIMEOUT = 3000;
  localparam tnoc_id_t NODE_ID = tnoc_id_t'(5);

  typedef struct packed {
    logic       head;
    logic       tail;
    tnoc_id_t   dest;
    tnoc_data_t data;
  } flit_t;

  logic       clk;
  logic       rst_n;
  tnoc_id_t   id_x;
  logic       local_in_valid, local_in_ready, local_in_head, local_in_tail;
  tnoc_id_t   local_in_dest;
  tnoc_data_t local_in_data;
  logic       link_in_valid, link_in_ready, link_in_head, link_in_tail;
  tnoc_id_t   link_in_dest;
  tnoc_data_t link_in_data;
  logic       local_out_valid, local_out_ready, local_out_head, local_out_tail;
  tnoc_id_t   local_out_dest;
  tnoc_data_t local_out_data;
  logic       link_out_valid, link_out_ready, link_out_head, link_out_tail;
  tnoc_id_t   link_out_dest;
  tnoc_data_t link_out_data;

  flit_t       exp_q [4][$]; // index is output * 2 + source input
  logic        pkt_open [2];
  int          pkt_src [2];
  logic [15:0] lfsr_state [4]; // streams 0 and 1 feed the inputs, 2 and 3 the output readies
  int          ready_mode;     // 0 ready, 1 stalled, 2 random
  logic        saw_full;
  int          errors;
  int          checks;
  int          cycles;
  string       cur_test;

  tnoc_router uut (.*);

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // galois LFSR with taps 16,14,13,11 stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int stream, input int n);
    logic [31:0] r;
    logic [15:0] s;
    r = '0;
    s = lfsr_state[stream];
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], s[0]};
      s = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    end
    lfsr_state[stream] = s;
    return r;
  endfunction

  function automatic tnoc_id_t pick_dest(input int stream, input logic to_local);
    tnoc_id_t d;
    d = tnoc_id_t'(rand_bits(stream, `TNOC_ID_WIDTH));
    if (to_local) return NODE_ID;
    if (d == NODE_ID) d = d ^ tnoc_id_t'(1);
    return d;
  endfunction

  function automatic int pending();
    int n;
    n = 0;
    for (int i = 0; i < 4; i++) n += exp_q[i].size();
    return n;
  endfunction

  task automatic compare_field(input string name, input logic [31:0] got,
                               input logic [31:0] want);
    checks++;
    assert (got === want) else begin
      errors++;
      $display("FAIL %0t %s: got %0h expected %0h", $time, name, got, want);
    end
  endtask

  task automatic check_flit(input int out, input flit_t got);
    string pname;
    int    idx;
    flit_t want;
    pname = (out == 0) ? "local_out" : "link_out";
    if (got.head) begin
      assert (!pkt_open[out]) else begin
        errors++;
        $display("%0t: %s began a new packet before the last one ended", $time, pname);
      end
      pkt_src[out] = int'(got.data[`TNOC_DATA_WIDTH-1]); // top payload bit tags the source
    end else begin
      assert (pkt_open[out]) else begin
        errors++;
        $display("%0t: %s sent a body flit with no packet open", $time, pname);
      end
    end
    idx = out * 2 + pkt_src[out];
    assert (exp_q[idx].size() != 0) else begin
      errors++;
      $display("%0t: %s delivered a flit that was never sent", $time, pname);
    end
    if (exp_q[idx].size() != 0) begin
      want = exp_q[idx].pop_front();
      compare_field({pname, "_head"}, 32'(got.head), 32'(want.head));
      compare_field({pname, "_tail"}, 32'(got.tail), 32'(want.tail));
      compare_field({pname, "_dest"}, 32'(got.dest), 32'(want.dest));
      compare_field({pname, "_data"}, got.data, want.data);
    end
    pkt_open[out] = !got.tail;
  endtask

  // outputs are settled at the falling edge, a transfer follows at the next rise
  always @(negedge clk) begin
    if (rst_n) begin
      if (local_out_valid && local_out_ready) begin
        check_flit(0, {local_out_head, local_out_tail, local_out_dest, local_out_data});
      end
      if (link_out_valid && link_out_ready) begin
        check_flit(1, {link_out_head, link_out_tail, link_out_dest, link_out_data});
      end
      if (!local_in_ready) saw_full = 1'b1;
    end
  end

  initial begin
    link_out_ready  = 1'b1;
    local_out_ready = 1'b1;
    forever begin
      @(posedge clk);
      #2;
      case (ready_mode)
        0: begin
          link_out_ready  = 1'b1;
          local_out_ready = 1'b1;
        end
        1: begin
          link_out_ready  = 1'b0;
          local_out_ready = 1'b0;
        end
        default: begin
          link_out_ready  = (rand_bits(2, 2) == 32'd3); // mostly stalled
          local_out_ready = (rand_bits(3, 1) == 32'd1);
        end
      endcase
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT) begin
      $display("timeout after %0d cycles, test %s never finished", cycles, cur_test);
      $display("checks %0d, errors %0d", checks, errors);
      $display("Test failed");
      $finish;
    end
  end

  task automatic set_ready_mode(input int mode);
    @(negedge clk);
    ready_mode = mode;
    @(posedge clk);
    #2;
  endtask

  // called 2 ns after a rising edge and returns at the same point after the transfer
  task automatic drive_flit(input int src, input flit_t f);
    logic accepted;
    if (src == 0) begin
      local_in_valid = 1'b1;
      {local_in_head, local_in_tail, local_in_dest, local_in_data} = f;
    end else begin
      link_in_valid = 1'b1;
      {link_in_head, link_in_tail, link_in_dest, link_in_data} = f;
    end
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      accepted = (src == 0) ? local_in_ready : link_in_ready;
      @(posedge clk);
      #2;
    end
  endtask

  task automatic send_packet(input int src, input tnoc_id_t dest, input int len);
    flit_t       f;
    logic [31:0] r;
    int          out;
    out = (dest == NODE_ID) ? 0 : 1; // own id goes local, anything else down the link
    for (int i = 0; i < len; i++) begin
      r = rand_bits(src, `TNOC_DATA_WIDTH - 1);
      f.head = (i == 0);
      f.tail = (i == len - 1);
      f.dest = dest;
      f.data = {src[0], r[`TNOC_DATA_WIDTH-2:0]};
      exp_q[out * 2 + src].push_back(f);
      drive_flit(src, f);
    end
    if (src == 0) local_in_valid = 1'b0;
    else link_in_valid = 1'b0;
  endtask

  task automatic wait_drained();
    while (pending() != 0) @(posedge clk);
    @(posedge clk);
    #2;
    assert (!pkt_open[0] && !pkt_open[1]) else begin
      errors++;
      $display("test %s left a packet without its tail flit", cur_test);
    end
  endtask

  task automatic check_reset_state();
    cur_test = "reset";
    compare_field("local_out_valid", 32'(local_out_valid), 32'd0);
    compare_field("link_out_valid", 32'(link_out_valid), 32'd0);
    compare_field("local_in_ready", 32'(local_in_ready), 32'd1);
    compare_field("link_in_ready", 32'(link_in_ready), 32'd1);
  endtask

  task automatic route_from_local();
    cur_test = "local routing";
    for (int i = 0; i < 8; i++) begin
      send_packet(0, pick_dest(0, (i % 3) == 2), (i % 4) + 1);
    end
    wait_drained();
  endtask

  task automatic route_from_link();
    cur_test = "link routing";
    for (int i = 0; i < 8; i++) begin
      send_packet(1, pick_dest(1, (i % 2) == 0), ((i + 1) % 4) + 1);
    end
    wait_drained();
  endtask

  task automatic contend_for_link();
    cur_test = "contention";
    for (int r = 0; r < 3; r++) begin
      fork
        send_packet(0, pick_dest(0, r == 2), 4);
        send_packet(1, pick_dest(1, r == 2), 3 + (r % 2));
      join
    end
    wait_drained();
  endtask

  task automatic stall_link_output();
    cur_test = "back-pressure";
    set_ready_mode(1);
    saw_full = 1'b0;
    fork
      begin
        for (int i = 0; i < 3; i++) send_packet(0, pick_dest(0, 1'b0), 4);
      end
      send_packet(1, NODE_ID, 3);
      begin
        repeat (20) @(posedge clk);
        set_ready_mode(2);
      end
    join
    wait_drained();
    set_ready_mode(0);
    assert (saw_full) else begin
      errors++;
      $display("local_in_ready never dropped while link_out was stalled");
    end
  endtask

  initial begin
    for (int k = 0; k < 4; k++) lfsr_state[k] = 16'd28821;
    errors = 0;
    checks = 0;
    cycles = 0;
    ready_mode = 0;
    saw_full = 1'b0;
    pkt_open[0] = 1'b0;
    pkt_open[1] = 1'b0;
    pkt_src[0] = 0;
    pkt_src[1] = 0;
    cur_test = "reset";
    id_x = NODE_ID;
    local_in_valid = 1'b0;
    local_in_head = 1'b0;
    local_in_tail = 1'b0;
    local_in_dest = '0;
    local_in_data = '0;
    link_in_valid = 1'b0;
    link_in_head = 1'b0;
    link_in_tail = 1'b0;
    link_in_dest = '0;
    link_in_data = '0;
    rst_n = 1'b0;
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;

    check_reset_state();
    route_from_local();
    route_from_link();
    contend_for_link();
    stall_link_output();

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* tnoc_router_chk.sv */
`timescale 1ns/1ns

module tnoc_router_chk (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 local_out_valid,
  input logic                 local_out_ready,
  input logic                 local_out_head,
  input logic                 local_out_tail,
  input tnoc_pkg::tnoc_id_t   local_out_dest,
  input tnoc_pkg::tnoc_data_t local_out_data,
  input logic                 link_out_valid,
  input logic                 link_out_ready,
  input logic                 link_out_head,
  input logic                 link_out_tail,
  input tnoc_pkg::tnoc_id_t   link_out_dest,
  input tnoc_pkg::tnoc_data_t link_out_data
);
  import tnoc_pkg::*;

  tnoc_lock_e local_lock;
  tnoc_lock_e link_lock;

  // a packet is open from the transfer of its head until its tail leaves
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      local_lock <= LOCK_IDLE;
      link_lock  <= LOCK_IDLE;
    end else begin
      if (local_out_valid && local_out_ready) local_lock <= local_out_tail ? LOCK_IDLE : LOCK_BUSY;
      if (link_out_valid && link_out_ready) link_lock <= link_out_tail ? LOCK_IDLE : LOCK_BUSY;
    end
  end

  local_quiet: assert property (@(posedge clk) !rst_n |=> !local_out_valid)
    else $error("local_out_valid high right after a reset cycle");
  link_quiet: assert property (@(posedge clk) !rst_n |=> !link_out_valid)
    else $error("link_out_valid high right after a reset cycle");

  local_hold: assert property (@(posedge clk) disable iff (!rst_n)
    local_out_valid && !local_out_ready |=> local_out_valid &&
      $stable({local_out_head, local_out_tail, local_out_dest, local_out_data}))
    else $error("local_out flit changed while stalled");
  link_hold: assert property (@(posedge clk) disable iff (!rst_n)
    link_out_valid && !link_out_ready |=> link_out_valid &&
      $stable({link_out_head, link_out_tail, link_out_dest, link_out_data}))
    else $error("link_out flit changed while stalled");

  // a head flit only when no packet is open, a body flit only inside one
  local_frame: assert property (@(posedge clk) disable iff (!rst_n)
    local_out_valid |-> (local_out_head == (local_lock == LOCK_IDLE)))
    else $error("local_out head flag does not match packet framing");
  link_frame: assert property (@(posedge clk) disable iff (!rst_n)
    link_out_valid |-> (link_out_head == (link_lock == LOCK_IDLE)))
    else $error("link_out head flag does not match packet framing");

endmodule

bind tnoc_router tnoc_router_chk u_chk (.*);

/* tnoc_router.sv */
`timescale 1ns/1ns

module tnoc_router (
  input  logic                 clk,
  input  logic                 rst_n,
  input  tnoc_pkg::tnoc_id_t   id_x,
  input  logic                 local_in_valid,
  output logic                 local_in_ready,
  input  logic                 local_in_head,
  input  logic                 local_in_tail,
  input  tnoc_pkg::tnoc_id_t   local_in_dest,
  input  tnoc_pkg::tnoc_data_t local_in_data,
  input  logic                 link_in_valid,
  output logic                 link_in_ready,
  input  logic                 link_in_head,
  input  logic                 link_in_tail,
  input  tnoc_pkg::tnoc_id_t   link_in_dest,
  input  tnoc_pkg::tnoc_data_t link_in_data,
  output logic                 local_out_valid,
  input  logic                 local_out_ready,
  output logic                 local_out_head,
  output logic                 local_out_tail,
  output tnoc_pkg::tnoc_id_t   local_out_dest,
  output tnoc_pkg::tnoc_data_t local_out_data,
  output logic                 link_out_valid,
  input  logic                 link_out_ready,
  output logic                 link_out_head,
  output logic                 link_out_tail,
  output tnoc_pkg::tnoc_id_t   link_out_dest,
  output tnoc_pkg::tnoc_data_t link_out_data
);
  import tnoc_pkg::*;

  // switch side of the local input, wired to switch port a
  logic       a_valid;
  logic       a_head;
  logic       a_tail;
  logic       a_route;
  tnoc_id_t   a_dest;
  tnoc_data_t a_data;
  logic       a_pop;

  // switch side of the link input, wired to switch port b
  logic       b_valid;
  logic       b_head;
  logic       b_tail;
  logic       b_route;
  tnoc_id_t   b_dest;
  tnoc_data_t b_data;
  logic       b_pop;

  tnoc_input_unit u_local_in (
    .clk        (clk),
    .rst_n      (rst_n),
    .id_x       (id_x),
    .in_valid   (local_in_valid),
    .in_head    (local_in_head),
    .in_tail    (local_in_tail),
    .in_dest    (local_in_dest),
    .in_data    (local_in_data),
    .in_ready   (local_in_ready),
    .fifo_valid (a_valid),
    .fifo_head  (a_head),
    .fifo_tail  (a_tail),
    .fifo_dest  (a_dest),
    .fifo_data  (a_data),
    .route      (a_route),
    .pop        (a_pop)
  );

  tnoc_input_unit u_link_in (
    .clk        (clk),
    .rst_n      (rst_n),
    .id_x       (id_x),
    .in_valid   (link_in_valid),
    .in_head    (link_in_head),
    .in_tail    (link_in_tail),
    .in_dest    (link_in_dest),
    .in_data    (link_in_data),
    .in_ready   (link_in_ready),
    .fifo_valid (b_valid),
    .fifo_head  (b_head),
    .fifo_tail  (b_tail),
    .fifo_dest  (b_dest),
    .fifo_data  (b_data),
    .route      (b_route),
    .pop        (b_pop)
  );

  tnoc_output_switch u_switch (
    .clk             (clk),
    .rst_n           (rst_n),
    .a_valid         (a_valid),
    .a_head          (a_head),
    .a_tail          (a_tail),
    .a_route         (a_route),
    .a_dest          (a_dest),
    .a_data          (a_data),
    .a_pop           (a_pop),
    .b_valid         (b_valid),
    .b_head          (b_head),
    .b_tail          (b_tail),
    .b_route         (b_route),
    .b_dest          (b_dest),
    .b_data          (b_data),
    .b_pop           (b_pop),
    .local_out_valid (local_out_valid),
    .local_out_head  (local_out_head),
    .local_out_tail  (local_out_tail),
    .local_out_dest  (local_out_dest),
    .local_out_data  (local_out_data),
    .local_out_ready (local_out_ready),
    .link_out_valid  (link_out_valid),
    .link_out_head   (link_out_head),
    .link_out_tail   (link_out_tail),
    .link_out_dest   (link_out_dest),
    .link_out_data   (link_out_data),
    .link_out_ready  (link_out_ready)
  );

endmodule

/* tnoc_output_switch.sv */
`timescale 1ns/1ns

module tnoc_output_switch (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 a_valid,
  input  logic                 a_head,
  input  logic                 a_tail,
  input  logic                 a_route,
  input  tnoc_pkg::tnoc_id_t   a_dest,
  input  tnoc_pkg::tnoc_data_t a_data,
  output logic                 a_pop,
  input  logic                 b_valid,
  input  logic                 b_head,
  input  logic                 b_tail,
  input  logic                 b_route,
  input  tnoc_pkg::tnoc_id_t   b_dest,
  input  tnoc_pkg::tnoc_data_t b_data,
  output logic                 b_pop,
  output logic                 local_out_valid,
  output logic                 local_out_head,
  output logic                 local_out_tail,
  output tnoc_pkg::tnoc_id_t   local_out_dest,
  output tnoc_pkg::tnoc_data_t local_out_data,
  input  logic                 local_out_ready,
  output logic                 link_out_valid,
  output logic                 link_out_head,
  output logic                 link_out_tail,
  output tnoc_pkg::tnoc_id_t   link_out_dest,
  output tnoc_pkg::tnoc_data_t link_out_data,
  input  logic                 link_out_ready
);
  import tnoc_pkg::*;

  // index 0 is the local output, index 1 the link output

  logic [1:0] out_ready;
  logic [1:0] match_a;
  logic [1:0] match_b;
  logic [1:0] req_a;
  logic [1:0] req_b;
  logic [1:0] grant;
  logic [1:0] sel;      // 0 picks input a, 1 picks input b
  logic [1:0] can_load;
  logic [1:0] move;
  logic [1:0] rr;       // set when input b has priority for the next head
  logic [1:0] owner;

  tnoc_lock_e lock_state [2];

  logic [1:0] mux_head;
  logic [1:0] mux_tail;
  tnoc_id_t   mux_dest [2];
  tnoc_data_t mux_data [2];

  logic [1:0] out_valid_q;
  logic [1:0] out_head_q;
  logic [1:0] out_tail_q;
  tnoc_id_t   out_dest_q [2];
  tnoc_data_t out_data_q [2];

  assign out_ready = {link_out_ready, local_out_ready};

  assign match_a = {a_valid && a_route, a_valid && !a_route};
  assign match_b = {b_valid && b_route, b_valid && !b_route};
  assign req_a   = match_a & {2{a_head}};
  assign req_b   = match_b & {2{b_head}};

  // an output register takes a new flit when it is empty or drains this cycle
  assign can_load = ~out_valid_q | out_ready;

  always_comb begin
    for (int o = 0; o < 2; o++) begin
      if (lock_state[o] == LOCK_IDLE) begin
        grant[o] = req_a[o] || req_b[o];
        sel[o]   = (req_a[o] && req_b[o]) ? rr[o] : req_b[o];
      end else begin
        grant[o] = owner[o] ? match_b[o] : match_a[o];
        sel[o]   = owner[o];
      end
      mux_head[o] = sel[o] ? b_head : a_head;
      mux_tail[o] = sel[o] ? b_tail : a_tail;
      mux_dest[o] = sel[o] ? b_dest : a_dest;
      mux_data[o] = sel[o] ? b_data : a_data;
    end
  end

  assign move = grant & can_load;

  // each input routes to one output only, so it is popped at most once
  assign a_pop = |(move & ~sel);
  assign b_pop = |(move & sel);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid_q <= '0;
      rr          <= '0;
      owner       <= '0;
      for (int o = 0; o < 2; o++) begin
        lock_state[o] <= LOCK_IDLE;
      end
    end else begin
      for (int o = 0; o < 2; o++) begin
        if (move[o]) begin
          out_valid_q[o] <= 1'b1;
        end else if (out_ready[o]) begin
          out_valid_q[o] <= 1'b0;
        end

        case (lock_state[o])
          LOCK_IDLE: begin
            if (move[o]) begin
              rr[o]    <= ~sel[o]; // the loser of this round goes first next time
              owner[o] <= sel[o];
              if (!mux_tail[o]) begin
                lock_state[o] <= LOCK_BUSY;
              end
            end
          end
          LOCK_BUSY: begin
            if (move[o] && mux_tail[o]) begin
              lock_state[o] <= LOCK_IDLE;
            end
          end
          default: lock_state[o] <= LOCK_IDLE;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int o = 0; o < 2; o++) begin
      if (move[o]) begin
        out_head_q[o] <= mux_head[o];
        out_tail_q[o] <= mux_tail[o];
        out_dest_q[o] <= mux_dest[o];
        out_data_q[o] <= mux_data[o];
      end
    end
  end

  assign local_out_valid = out_valid_q[0];
  assign local_out_head  = out_head_q[0];
  assign local_out_tail  = out_tail_q[0];
  assign local_out_dest  = out_dest_q[0];
  assign local_out_data  = out_data_q[0];

  assign link_out_valid = out_valid_q[1];
  assign link_out_head  = out_head_q[1];
  assign link_out_tail  = out_tail_q[1];
  assign link_out_dest  = out_dest_q[1];
  assign link_out_data  = out_data_q[1];

endmodule

/* tnoc_input_unit.sv */
`timescale 1ns/1ns

`include "tnoc_defines.svh"

module tnoc_input_unit (
  input  logic                 clk,
  input  logic                 rst_n,
  input  tnoc_pkg::tnoc_id_t   id_x,
  input  logic                 in_valid,
  input  logic                 in_head,
  input  logic                 in_tail,
  input  tnoc_pkg::tnoc_id_t   in_dest,
  input  tnoc_pkg::tnoc_data_t in_data,
  output logic                 in_ready,
  output logic                 fifo_valid,
  output logic                 fifo_head,
  output logic                 fifo_tail,
  output tnoc_pkg::tnoc_id_t   fifo_dest,
  output tnoc_pkg::tnoc_data_t fifo_data,
  output logic                 route,
  input  logic                 pop
);
  import tnoc_pkg::*;

  localparam int DEPTH = `TNOC_FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic       mem_head [DEPTH];
  logic       mem_tail [DEPTH];
  tnoc_id_t   mem_dest [DEPTH];
  tnoc_data_t mem_data [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  logic full;
  logic empty;
  logic wr_en;
  logic rd_en;
  logic head_route;
  logic route_q;

  assign full  = (count == CNT_W'(DEPTH));
  assign empty = (count == '0);

  assign in_ready = !full;
  assign wr_en    = in_valid && in_ready;
  assign rd_en    = pop && !empty; // an empty FIFO is never popped

  // flit storage is written at wr_ptr
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem_head[wr_ptr] <= in_head;
      mem_tail[wr_ptr] <= in_tail;
      mem_dest[wr_ptr] <= in_dest;
      mem_data[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign fifo_valid = !empty;
  assign fifo_head  = mem_head[rd_ptr];
  assign fifo_tail  = mem_tail[rd_ptr];
  assign fifo_dest  = mem_dest[rd_ptr];
  assign fifo_data  = mem_data[rd_ptr];

  // 0 sends the packet to the local output, 1 sends it down the link
  assign head_route = (fifo_dest != id_x);

  // body and tail flits follow the route taken by their head
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      route_q <= 1'b0;
    end else if (rd_en && fifo_head) begin
      route_q <= head_route;
    end
  end

  assign route = fifo_head ? head_route : route_q;

endmodule

/* tnoc_pkg.sv */
`include "tnoc_defines.svh"

package tnoc_pkg;

  // node id and flit destination
  typedef logic [`TNOC_ID_WIDTH-1:0] tnoc_id_t;

  // flit payload
  typedef logic [`TNOC_DATA_WIDTH-1:0] tnoc_data_t;

  // an output is either free for a new head flit or owned by one packet
  typedef enum logic {
    LOCK_IDLE = 1'b0,
    LOCK_BUSY = 1'b1
  } tnoc_lock_e;

endpackage

/* tnoc_defines.svh */
`ifndef TNOC_DEFINES_SVH
`define TNOC_DEFINES_SVH

// width of a node id and of the destination field of a head flit
`define TNOC_ID_WIDTH 4

// flit payload width
`define TNOC_DATA_WIDTH 32

// entries per input FIFO
`define TNOC_FIFO_DEPTH 4

`endif
